/* src/ir_pkg.sv */
`default_nettype none

package ir_pkg;

    // Audio samples and the test-pulse amplitude share this width.
    localparam int SAMPLE_WIDTH = 16;

    // Delay and pulse-length counters use the configuration data width.
    localparam int COUNT_WIDTH = 16;

    // Recorder flow: wait for the pulse, let the delay pass, then capture.
    typedef enum logic [1:0] {
        REC_IDLE    = 2'd0,
        REC_DELAY   = 2'd1,
        REC_CAPTURE = 2'd2
    } rec_state_t;

    // Opcodes carried with each configuration write strobe.
    typedef enum logic [1:0] {
        CFG_DELAY     = 2'd0,
        CFG_AMPLITUDE = 2'd1,
        CFG_PULSE_LEN = 2'd2,
        CFG_START     = 2'd3
    } cfg_op_t;

endpackage

`default_nettype wire

/* src/ir_config_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module ir_config_regs (
    input  wire                                   audio_clk,
    input  wire                                   rst_in,
    input  wire                                   cfg_write,
    input  wire ir_pkg::cfg_op_t                  cfg_op,
    input  wire [ir_pkg::COUNT_WIDTH-1:0]         cfg_data,
    input  wire                                   impulse_recorded,
    output logic [ir_pkg::COUNT_WIDTH-1:0]        delay_length,
    output logic signed [ir_pkg::SAMPLE_WIDTH-1:0] pulse_amp,
    output logic [ir_pkg::COUNT_WIDTH-1:0]        pulse_len,
    output logic                                  start_pulse,
    output logic                                  busy
);

    // A single-sample pulse is the shortest useful test signal.
    localparam logic [ir_pkg::COUNT_WIDTH-1:0] PULSE_LEN_RESET = 1;

    logic write_accepted;

    // Nothing may change while a capture is in flight.
    assign write_accepted = cfg_write && !busy;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            delay_length <= '0;
            pulse_amp    <= '0;
            pulse_len    <= PULSE_LEN_RESET;
            start_pulse  <= 1'b0;
            busy         <= 1'b0;
        end else begin
            start_pulse <= 1'b0;

            // The recorder reports the last sample written.
            if (impulse_recorded) begin
                busy <= 1'b0;
            end

            if (write_accepted) begin
                case (cfg_op)
                    ir_pkg::CFG_DELAY: begin
                        delay_length <= cfg_data;
                    end
                    ir_pkg::CFG_AMPLITUDE: begin
                        pulse_amp <= $signed(cfg_data[ir_pkg::SAMPLE_WIDTH-1:0]);
                    end
                    ir_pkg::CFG_PULSE_LEN: begin
                        pulse_len <= cfg_data;
                    end
                    ir_pkg::CFG_START: begin
                        // Start and busy rise together so a back-to-back
                        // start is already blocked.
                        start_pulse <= 1'b1;
                        busy        <= 1'b1;
                    end
                    default: begin
                        start_pulse <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* src/impulse_generator.sv */
`timescale 1ns/10ps
`default_nettype none

module impulse_generator (
    input  wire                                    audio_clk,
    input  wire                                    rst_in,
    input  wire                                    audio_trigger,
    input  wire                                    start_pulse,
    input  wire signed [ir_pkg::SAMPLE_WIDTH-1:0]  pulse_amp,
    input  wire [ir_pkg::COUNT_WIDTH-1:0]          pulse_len,
    output logic signed [ir_pkg::SAMPLE_WIDTH-1:0] speaker_out,
    output logic                                   impulse_done
);

    localparam logic [ir_pkg::COUNT_WIDTH-1:0] FIRST_STROBE = 1;

    typedef enum logic [1:0] {
        GEN_IDLE    = 2'd0,
        GEN_ARMED   = 2'd1,
        GEN_PLAYING = 2'd2
    } gen_state_t;

    gen_state_t                   state;
    logic [ir_pkg::COUNT_WIDTH-1:0] strobe_cnt;

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state        <= GEN_IDLE;
            strobe_cnt   <= '0;
            speaker_out  <= '0;
            impulse_done <= 1'b0;
        end else begin
            impulse_done <= 1'b0;

            case (state)
                GEN_IDLE: begin
                    if (start_pulse) begin
                        state <= GEN_ARMED;
                    end
                end
                GEN_ARMED: begin
                    // The pulse starts on a sample boundary.
                    if (audio_trigger) begin
                        speaker_out <= pulse_amp;
                        strobe_cnt  <= FIRST_STROBE;
                        state       <= GEN_PLAYING;
                    end
                end
                GEN_PLAYING: begin
                    if (audio_trigger) begin
                        // A length of zero still gives one sample of pulse.
                        if (strobe_cnt >= pulse_len) begin
                            speaker_out  <= '0;
                            impulse_done <= 1'b1;
                            state        <= GEN_IDLE;
                        end else begin
                            strobe_cnt <= strobe_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    speaker_out <= '0;
                    state       <= GEN_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/impulse_recorder.sv */
`timescale 1ns/10ps
`default_nettype none

module impulse_recorder #(
    parameter int IMPULSE_LENGTH = 4096
) (
    input  wire                                         audio_clk,
    input  wire                                         rst_in,
    input  wire                                         audio_trigger,
    input  wire                                         impulse_done,
    input  wire [ir_pkg::COUNT_WIDTH-1:0]               delay_length,
    input  wire signed [ir_pkg::SAMPLE_WIDTH-1:0]       mic_in,
    output logic                                        write_enable,
    output logic [((IMPULSE_LENGTH > 1) ? $clog2(IMPULSE_LENGTH) : 1)-1:0] write_addr,
    output logic signed [ir_pkg::SAMPLE_WIDTH-1:0]      write_data,
    output logic                                        impulse_recorded
);

    localparam int ADDR_WIDTH = (IMPULSE_LENGTH > 1) ? $clog2(IMPULSE_LENGTH) : 1;
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = ADDR_WIDTH'(IMPULSE_LENGTH - 1);

    ir_pkg::rec_state_t             state;
    ir_pkg::rec_state_t             state_next;
    logic [ir_pkg::COUNT_WIDTH-1:0] delay_cnt;
    logic [ADDR_WIDTH-1:0]          sample_cnt;
    logic                           capture_strobe;
    logic                           last_capture;

    always_comb begin
        state_next     = state;
        capture_strobe = 1'b0;

        case (state)
            ir_pkg::REC_IDLE: begin
                if (impulse_done) begin
                    state_next = ir_pkg::REC_DELAY;
                end
            end
            ir_pkg::REC_DELAY: begin
                // Once delay_length strobes have gone by, this strobe
                // is already the first sample of the response.
                if (audio_trigger && (delay_cnt == delay_length)) begin
                    capture_strobe = 1'b1;
                    state_next     = ir_pkg::REC_CAPTURE;
                end
            end
            ir_pkg::REC_CAPTURE: begin
                capture_strobe = audio_trigger;
            end
            default: begin
                state_next = ir_pkg::REC_IDLE;
            end
        endcase

        last_capture = capture_strobe && (sample_cnt == LAST_ADDR);
        if (last_capture) begin
            state_next = ir_pkg::REC_IDLE;
        end
    end

    always_ff @(posedge audio_clk) begin
        if (rst_in) begin
            state            <= ir_pkg::REC_IDLE;
            delay_cnt        <= '0;
            sample_cnt       <= '0;
            write_enable     <= 1'b0;
            impulse_recorded <= 1'b0;
        end else begin
            state            <= state_next;
            write_enable     <= capture_strobe;
            impulse_recorded <= last_capture;

            if (state == ir_pkg::REC_IDLE) begin
                delay_cnt  <= '0;
                sample_cnt <= '0;
            end else begin
                if ((state == ir_pkg::REC_DELAY) && audio_trigger && !capture_strobe) begin
                    delay_cnt <= delay_cnt + 1'b1;
                end
                if (capture_strobe) begin
                    sample_cnt <= sample_cnt + 1'b1;
                end
            end
        end
    end

    // Address and sample line up with write_enable one cycle after the strobe.
    always_ff @(posedge audio_clk) begin
        if (capture_strobe) begin
            write_addr <= sample_cnt;
            write_data <= mic_in;
        end
    end

endmodule

`default_nettype wire

/* src/ir_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module ir_memory #(
    parameter int IMPULSE_LENGTH = 4096
) (
    input  wire                                         audio_clk,
    input  wire                                         write_enable,
    input  wire [((IMPULSE_LENGTH > 1) ? $clog2(IMPULSE_LENGTH) : 1)-1:0] write_addr,
    input  wire signed [ir_pkg::SAMPLE_WIDTH-1:0]       write_data,
    input  wire [((IMPULSE_LENGTH > 1) ? $clog2(IMPULSE_LENGTH) : 1)-1:0] read_addr,
    output logic signed [ir_pkg::SAMPLE_WIDTH-1:0]      read_data
);

    logic signed [ir_pkg::SAMPLE_WIDTH-1:0] mem [0:IMPULSE_LENGTH-1];

    always_ff @(posedge audio_clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // Registered read so the array maps onto a block RAM.
    always_ff @(posedge audio_clk) begin
        read_data <= mem[read_addr];
    end

endmodule

`default_nettype wire

/* src/ir_capture_top.sv */
`timescale 1ns/10ps
`default_nettype none

module ir_capture_top #(
    parameter int IMPULSE_LENGTH = 4096
) (
    input  wire                                         audio_clk,
    input  wire                                         rst_in,
    input  wire                                         audio_trigger,
    input  wire                                         cfg_write,
    input  wire ir_pkg::cfg_op_t                        cfg_op,
    input  wire [ir_pkg::COUNT_WIDTH-1:0]               cfg_data,
    input  wire signed [ir_pkg::SAMPLE_WIDTH-1:0]       mic_in,
    input  wire [((IMPULSE_LENGTH > 1) ? $clog2(IMPULSE_LENGTH) : 1)-1:0] read_addr,
    output logic signed [ir_pkg::SAMPLE_WIDTH-1:0]      speaker_out,
    output logic                                        busy,
    output logic                                        impulse_recorded,
    output logic signed [ir_pkg::SAMPLE_WIDTH-1:0]      read_data
);

    localparam int ADDR_WIDTH = (IMPULSE_LENGTH > 1) ? $clog2(IMPULSE_LENGTH) : 1;

    logic [ir_pkg::COUNT_WIDTH-1:0]         delay_length;
    logic signed [ir_pkg::SAMPLE_WIDTH-1:0] pulse_amp;
    logic [ir_pkg::COUNT_WIDTH-1:0]         pulse_len;
    logic                                   start_pulse;
    logic                                   impulse_done;
    logic                                   write_enable;
    logic [ADDR_WIDTH-1:0]                  write_addr;
    logic signed [ir_pkg::SAMPLE_WIDTH-1:0] write_data;

    ir_config_regs u_config_regs (
        .audio_clk        (audio_clk),
        .rst_in           (rst_in),
        .cfg_write        (cfg_write),
        .cfg_op           (cfg_op),
        .cfg_data         (cfg_data),
        .impulse_recorded (impulse_recorded),
        .delay_length     (delay_length),
        .pulse_amp        (pulse_amp),
        .pulse_len        (pulse_len),
        .start_pulse      (start_pulse),
        .busy             (busy)
    );

    // Drives the speaker with the rectangular test pulse.
    impulse_generator u_impulse_generator (
        .audio_clk     (audio_clk),
        .rst_in        (rst_in),
        .audio_trigger (audio_trigger),
        .start_pulse   (start_pulse),
        .pulse_amp     (pulse_amp),
        .pulse_len     (pulse_len),
        .speaker_out   (speaker_out),
        .impulse_done  (impulse_done)
    );

    impulse_recorder #(
        .IMPULSE_LENGTH (IMPULSE_LENGTH)
    ) u_impulse_recorder (
        .audio_clk        (audio_clk),
        .rst_in           (rst_in),
        .audio_trigger    (audio_trigger),
        .impulse_done     (impulse_done),
        .delay_length     (delay_length),
        .mic_in           (mic_in),
        .write_enable     (write_enable),
        .write_addr       (write_addr),
        .write_data       (write_data),
        .impulse_recorded (impulse_recorded)
    );

    // The read port belongs to the convolution stage.
    ir_memory #(
        .IMPULSE_LENGTH (IMPULSE_LENGTH)
    ) u_ir_memory (
        .audio_clk    (audio_clk),
        .write_enable (write_enable),
        .write_addr   (write_addr),
        .write_data   (write_data),
        .read_addr    (read_addr),
        .read_data    (read_data)
    );

endmodule

`default_nettype wire

/* verif/tb_ir_capture.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_ir_capture;

    localparam int IMPULSE_LENGTH = 32;
    localparam int ADDR_WIDTH     = $clog2(IMPULSE_LENGTH);
    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 5;
    localparam int STROBE_PERIOD  = 6;
    localparam int NUM_CAPTURES   = 3;
    localparam int MAX_PULSE_LEN  = 3;
    localparam int MAX_DELAY      = 5;
    localparam int TIMEOUT_CYCLES = STROBE_PERIOD *
        (NUM_CAPTURES * (1 + MAX_PULSE_LEN + MAX_DELAY + IMPULSE_LENGTH) + 20) + 1000;

    logic                   audio_clk = 1'b0;
    logic                   rst_in;
    logic                   audio_trigger;
    logic                   cfg_write;
    ir_pkg::cfg_op_t        cfg_op;
    logic [15:0]            cfg_data;
    logic signed [15:0]     mic_in;
    logic [ADDR_WIDTH-1:0]  read_addr;
    logic signed [15:0]     speaker_out;
    logic                   busy;
    logic                   impulse_recorded;
    logic signed [15:0]     read_data;

    // The reference model tracks the strobe count from each start.
    int                     m_delay;
    int                     m_len;
    logic signed [15:0]     m_amp;
    logic                   m_busy;
    logic                   m_running;
    int                     rel_strobe;
    logic signed [15:0]     exp_speaker;
    logic                   exp_recorded;
    logic signed [15:0]     exp_mem [0:IMPULSE_LENGTH-1];

    logic [31:0]            rng_state;
    int                     strobe_phase;
    int                     cycle_count = 0;
    int                     rec_pulses = 0;
    int                     mon_checks = 0;
    int                     mon_errors = 0;
    int                     seq_checks = 0;
    int                     seq_errors = 0;
    int                     prop_errors = 0;

    ir_capture_top #(
        .IMPULSE_LENGTH (IMPULSE_LENGTH)
    ) uut (
        .audio_clk        (audio_clk),
        .rst_in           (rst_in),
        .audio_trigger    (audio_trigger),
        .cfg_write        (cfg_write),
        .cfg_op           (cfg_op),
        .cfg_data         (cfg_data),
        .mic_in           (mic_in),
        .read_addr        (read_addr),
        .speaker_out      (speaker_out),
        .busy             (busy),
        .impulse_recorded (impulse_recorded),
        .read_data        (read_data)
    );

    always #(CLK_PERIOD / 2) audio_clk = ~audio_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Free-running sample strobe. The microphone takes a new value on each one.
    initial begin
        audio_trigger = 1'b0;
        mic_in        = '0;
        rng_state     = 32'd77;
        strobe_phase  = 0;
        forever begin
            @(posedge audio_clk);
            #1;
            if (strobe_phase == STROBE_PERIOD - 1) begin
                strobe_phase  = 0;
                audio_trigger = 1'b1;
                rng_state     = xorshift32(rng_state);
                mic_in        = rng_state[15:0];
            end else begin
                strobe_phase  = strobe_phase + 1;
                audio_trigger = 1'b0;
            end
        end
    end

    always @(posedge audio_clk) begin : model_update
        int rel_next;
        int first_cap;
        if (rst_in) begin
            m_delay      <= 0;
            m_amp        <= '0;
            m_len        <= 1;
            m_busy       <= 1'b0;
            m_running    <= 1'b0;
            rel_strobe   <= 0;
            exp_speaker  <= '0;
            exp_recorded <= 1'b0;
        end else begin
            exp_recorded <= 1'b0;
            if (exp_recorded) begin
                m_busy <= 1'b0;
            end
            if (cfg_write && !m_busy) begin
                case (cfg_op)
                    ir_pkg::CFG_DELAY:     m_delay <= int'(cfg_data);
                    ir_pkg::CFG_AMPLITUDE: m_amp <= cfg_data;
                    ir_pkg::CFG_PULSE_LEN: m_len <= int'(cfg_data);
                    default: begin
                        m_busy     <= 1'b1;
                        m_running  <= 1'b1;
                        rel_strobe <= 0;
                    end
                endcase
            end
            if (m_running && audio_trigger) begin
                rel_next   = rel_strobe + 1;
                first_cap  = m_len + m_delay + 2;
                rel_strobe <= rel_next;
                if (rel_next == 1) begin
                    exp_speaker <= m_amp;
                end
                if (rel_next == m_len + 1) begin
                    exp_speaker <= '0;
                end
                if (rel_next >= first_cap && rel_next < first_cap + IMPULSE_LENGTH) begin
                    exp_mem[rel_next - first_cap] <= mic_in;
                end
                if (rel_next == first_cap + IMPULSE_LENGTH - 1) begin
                    exp_recorded <= 1'b1;
                    m_running    <= 1'b0;
                end
            end
        end
    end

    // Outputs settle after the rising edge and are compared on the falling edge.
    always @(negedge audio_clk) begin
        if (!rst_in) begin
            mon_checks = mon_checks + 3;
            if (impulse_recorded) begin
                rec_pulses = rec_pulses + 1;
            end
            assert (speaker_out === exp_speaker) else begin
                mon_errors = mon_errors + 1;
                $display("Fail speaker_out expected 0x%h got 0x%h", exp_speaker, speaker_out);
            end
            assert (busy === m_busy) else begin
                mon_errors = mon_errors + 1;
                $display("Fail busy expected 0x%h got 0x%h", m_busy, busy);
            end
            assert (impulse_recorded === exp_recorded) else begin
                mon_errors = mon_errors + 1;
                $display("Fail impulse_recorded expected 0x%h got 0x%h",
                         exp_recorded, impulse_recorded);
            end
        end
    end

    recorded_then_idle: assert property (@(posedge audio_clk) disable iff (rst_in)
        impulse_recorded |=> (!impulse_recorded && !busy))
    else begin
        prop_errors = prop_errors + 1;
        $display("impulse_recorded was not a single pulse followed by busy going low");
    end

    always @(posedge audio_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the capture sequence did not finish",
                     cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        seq_checks = seq_checks + 1;
        assert (actual === expected) else begin
            seq_errors = seq_errors + 1;
            $display("Fail %s expected 0x%h got 0x%h", name, expected, actual);
        end
    endtask

    task automatic write_register(input ir_pkg::cfg_op_t op, input logic [15:0] data);
        @(posedge audio_clk);
        #1;
        cfg_write = 1'b1;
        cfg_op    = op;
        cfg_data  = data;
        @(posedge audio_clk);
        #1;
        cfg_write = 1'b0;
    endtask

    // Issuing the start just after a strobe keeps the arming well clear of the next one.
    task automatic issue_start;
        @(posedge audio_clk);
        while (audio_trigger !== 1'b1) begin
            @(posedge audio_clk);
        end
        #1;
        cfg_write = 1'b1;
        cfg_op    = ir_pkg::CFG_START;
        cfg_data  = '0;
        @(posedge audio_clk);
        #1;
        cfg_write = 1'b0;
    endtask

    task automatic wait_for_recorded;
        @(posedge audio_clk);
        #1;
        while (impulse_recorded !== 1'b1) begin
            @(posedge audio_clk);
            #1;
        end
    endtask

    task automatic read_back;
        for (int i = 0; i <= IMPULSE_LENGTH; i++) begin
            @(posedge audio_clk);
            #1;
            if (i < IMPULSE_LENGTH) begin
                read_addr = ADDR_WIDTH'(i);
            end
            // The new address must not reach read_data before the next edge.
            #1;
            if (i > 0) begin
                check_equal($sformatf("read_data[%0d]", i - 1), exp_mem[i - 1], read_data);
            end
        end
    endtask

    initial begin : main_sequence
        int total_errors;
        rst_in    = 1'b1;
        cfg_write = 1'b0;
        cfg_op    = ir_pkg::CFG_DELAY;
        cfg_data  = '0;
        read_addr = '0;
        repeat (RESET_CYCLES) @(posedge audio_clk);
        #1;
        rst_in = 1'b0;
        @(posedge audio_clk);
        #1;
        check_equal("busy", 0, busy);
        check_equal("impulse_recorded", 0, impulse_recorded);
        check_equal("speaker_out", 0, speaker_out);

        write_register(ir_pkg::CFG_AMPLITUDE, 16'h4000);
        write_register(ir_pkg::CFG_PULSE_LEN, 16'd3);
        write_register(ir_pkg::CFG_DELAY, 16'd5);
        issue_start();
        wait_for_recorded();
        read_back();

        // Shortest pulse with no delay, negative amplitude.
        write_register(ir_pkg::CFG_DELAY, 16'd0);
        write_register(ir_pkg::CFG_PULSE_LEN, 16'd1);
        write_register(ir_pkg::CFG_AMPLITUDE, 16'hE000);
        issue_start();
        wait_for_recorded();
        read_back();

        write_register(ir_pkg::CFG_DELAY, 16'd2);
        write_register(ir_pkg::CFG_PULSE_LEN, 16'd2);
        issue_start();
        repeat (3) @(posedge audio_clk);
        #1;
        check_equal("busy", 1, busy);
        write_register(ir_pkg::CFG_DELAY, 16'd9);
        // The pulse is over by now and the generator would accept a new start.
        repeat (STROBE_PERIOD * 8) @(posedge audio_clk);
        write_register(ir_pkg::CFG_START, 16'd0);
        wait_for_recorded();
        read_back();
        repeat (STROBE_PERIOD * 4) @(posedge audio_clk);
        check_equal("impulse_recorded pulse count", NUM_CAPTURES, rec_pulses);

        total_errors = mon_errors + seq_errors + prop_errors;
        $display("Checks: %0d, errors: %0d (monitor %0d, sequence %0d, property %0d)",
                 mon_checks + seq_checks, total_errors, mon_errors, seq_errors, prop_errors);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
src/ir_pkg.sv
src/ir_config_regs.sv
src/impulse_generator.sv
src/impulse_recorder.sv
src/ir_memory.sv
src/ir_capture_top.sv
verif/tb_ir_capture.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_ir_capture
FILELIST    ?= sim.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
TIMESCALE   ?= 1ns/10ps
JOBS        ?= 0
PASS_STRING ?= TB PASSED

COMMON_FLAGS = --timing --assert --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS)

sim:
	$(VERILATOR) --binary -j $(JOBS) $(COMMON_FLAGS) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_STRING)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
